// ==== design/rv_decoder_params.svh ====
`ifndef RV_DECODER_PARAMS_SVH
`define RV_DECODER_PARAMS_SVH

// Instruction and immediate width
`define XLEN 32

`define REG_ADDR_W 5

// Internal operation code
`define OP_W 5

`define OPCODE_W 7

`endif

// ==== design/rv_decoder_pkg.sv ====
`include "rv_decoder_params.svh"

package rv_decoder_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Encodings kept compatible with the existing execute stage
    typedef enum logic [`OP_W-1:0] {
        OP_ADD   = 5'd0,
        OP_AND   = 5'd1,
        OP_OR    = 5'd2,
        OP_SLL   = 5'd3,
        OP_SRL   = 5'd4,
        OP_SLT   = 5'd5,
        OP_SLTU  = 5'd6,
        OP_SRA   = 5'd7,
        OP_SUB   = 5'd8,
        OP_XOR   = 5'd9,
        OP_BEQ   = 5'd10,
        OP_BGE   = 5'd11,
        OP_BNE   = 5'd12,
        OP_BGEU  = 5'd13,
        OP_LUI   = 5'd14,
        OP_AUIPC = 5'd15,
        OP_JAL   = 5'd16,
        OP_JALR  = 5'd17,
        OP_LB    = 5'd18,
        OP_LH    = 5'd19,
        OP_LW    = 5'd20,
        OP_LBU   = 5'd21,
        OP_LHU   = 5'd22,
        OP_SB    = 5'd23,
        OP_SH    = 5'd24,
        OP_SW    = 5'd25,
        OP_BLT   = 5'd26,
        OP_BLTU  = 5'd27,
        OP_NONE  = 5'd31    // Illegal or empty slot
    } op_e;

    typedef enum logic [`OPCODE_W-1:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        FMT_NONE, FMT_R, FMT_I, FMT_SHAMT, FMT_S, FMT_B, FMT_U, FMT_J
    } imm_fmt_e;

endpackage

// ==== design/rv_op_decode.sv ====
`timescale 1ns/1ns

module rv_op_decode (
    input  rv_decoder_pkg::word_t    instruction,
    output rv_decoder_pkg::op_e      op_next,
    output rv_decoder_pkg::imm_fmt_e fmt
);

    rv_decoder_pkg::opcode_e opcode;
    rv_decoder_pkg::imm_fmt_e fmt_raw;
    logic [2:0] funct3;
    logic       alt;    // Bit 30 picks SUB and SRA

    // Compressed words never match since their low bits are not 11
    assign opcode = rv_decoder_pkg::opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign alt    = instruction[30];

    always_comb begin
        op_next = rv_decoder_pkg::OP_NONE;
        fmt_raw = rv_decoder_pkg::FMT_NONE;
        case (opcode)
            rv_decoder_pkg::OPC_LUI: begin
                op_next = rv_decoder_pkg::OP_LUI;
                fmt_raw = rv_decoder_pkg::FMT_U;
            end
            rv_decoder_pkg::OPC_AUIPC: begin
                op_next = rv_decoder_pkg::OP_AUIPC;
                fmt_raw = rv_decoder_pkg::FMT_U;
            end
            rv_decoder_pkg::OPC_JAL: begin
                op_next = rv_decoder_pkg::OP_JAL;
                fmt_raw = rv_decoder_pkg::FMT_J;
            end
            rv_decoder_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) op_next = rv_decoder_pkg::OP_JALR;
                fmt_raw = rv_decoder_pkg::FMT_I;
            end
            rv_decoder_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000: op_next = rv_decoder_pkg::OP_BEQ;
                    3'b001: op_next = rv_decoder_pkg::OP_BNE;
                    3'b100: op_next = rv_decoder_pkg::OP_BLT;
                    3'b101: op_next = rv_decoder_pkg::OP_BGE;
                    3'b110: op_next = rv_decoder_pkg::OP_BLTU;
                    3'b111: op_next = rv_decoder_pkg::OP_BGEU;
                    default: op_next = rv_decoder_pkg::OP_NONE;
                endcase
                fmt_raw = rv_decoder_pkg::FMT_B;
            end
            rv_decoder_pkg::OPC_LOAD: begin
                case (funct3)
                    3'b000: op_next = rv_decoder_pkg::OP_LB;
                    3'b001: op_next = rv_decoder_pkg::OP_LH;
                    3'b010: op_next = rv_decoder_pkg::OP_LW;
                    3'b100: op_next = rv_decoder_pkg::OP_LBU;
                    3'b101: op_next = rv_decoder_pkg::OP_LHU;
                    default: op_next = rv_decoder_pkg::OP_NONE;
                endcase
                fmt_raw = rv_decoder_pkg::FMT_I;
            end
            rv_decoder_pkg::OPC_STORE: begin
                case (funct3)
                    3'b000: op_next = rv_decoder_pkg::OP_SB;
                    3'b001: op_next = rv_decoder_pkg::OP_SH;
                    3'b010: op_next = rv_decoder_pkg::OP_SW;
                    default: op_next = rv_decoder_pkg::OP_NONE;
                endcase
                fmt_raw = rv_decoder_pkg::FMT_S;
            end
            rv_decoder_pkg::OPC_OP_IMM: begin
                fmt_raw = rv_decoder_pkg::FMT_I;
                case (funct3)
                    3'b000: op_next = rv_decoder_pkg::OP_ADD;
                    3'b010: op_next = rv_decoder_pkg::OP_SLT;
                    3'b011: op_next = rv_decoder_pkg::OP_SLTU;
                    3'b100: op_next = rv_decoder_pkg::OP_XOR;
                    3'b110: op_next = rv_decoder_pkg::OP_OR;
                    3'b111: op_next = rv_decoder_pkg::OP_AND;
                    3'b001: begin
                        op_next = rv_decoder_pkg::OP_SLL;
                        fmt_raw = rv_decoder_pkg::FMT_SHAMT;
                    end
                    default: begin    // 101 selects a logical or arithmetic right shift
                        op_next = alt ? rv_decoder_pkg::OP_SRA : rv_decoder_pkg::OP_SRL;
                        fmt_raw = rv_decoder_pkg::FMT_SHAMT;
                    end
                endcase
            end
            rv_decoder_pkg::OPC_OP: begin
                fmt_raw = rv_decoder_pkg::FMT_R;
                case (funct3)
                    3'b000: op_next = alt ? rv_decoder_pkg::OP_SUB : rv_decoder_pkg::OP_ADD;
                    3'b001: op_next = rv_decoder_pkg::OP_SLL;
                    3'b010: op_next = rv_decoder_pkg::OP_SLT;
                    3'b011: op_next = rv_decoder_pkg::OP_SLTU;
                    3'b100: op_next = rv_decoder_pkg::OP_XOR;
                    3'b101: op_next = alt ? rv_decoder_pkg::OP_SRA : rv_decoder_pkg::OP_SRL;
                    3'b110: op_next = rv_decoder_pkg::OP_OR;
                    default: op_next = rv_decoder_pkg::OP_AND;
                endcase
            end
            default: op_next = rv_decoder_pkg::OP_NONE;    // Zero word lands here too
        endcase
    end

    // An undefined funct3 kills the format as well
    assign fmt = (op_next == rv_decoder_pkg::OP_NONE) ? rv_decoder_pkg::FMT_NONE : fmt_raw;

endmodule

// ==== design/rv_imm_gen.sv ====
`timescale 1ns/1ns
`include "rv_decoder_params.svh"

module rv_imm_gen (
    input  rv_decoder_pkg::word_t    instruction,
    input  rv_decoder_pkg::imm_fmt_e fmt,
    output rv_decoder_pkg::word_t    imm_next,
    output logic                     has_imm_next
);

    logic sign;

    assign sign = instruction[31];

    always_comb begin
        has_imm_next = 1'b1;
        case (fmt)
            rv_decoder_pkg::FMT_R: begin
                imm_next     = '1;    // Marker for register-register ops
                has_imm_next = 1'b0;
            end
            rv_decoder_pkg::FMT_I: begin
                imm_next = {{(`XLEN-12){sign}}, instruction[31:20]};
            end
            rv_decoder_pkg::FMT_SHAMT: begin
                // Shift amount, never sign extended
                imm_next = {{(`XLEN-5){1'b0}}, instruction[24:20]};
            end
            rv_decoder_pkg::FMT_S: begin
                imm_next = {{(`XLEN-12){sign}}, instruction[31:25], instruction[11:7]};
            end
            rv_decoder_pkg::FMT_B: begin
                imm_next = {{(`XLEN-13){sign}}, sign, instruction[7],
                            instruction[30:25], instruction[11:8], 1'b0};
            end
            rv_decoder_pkg::FMT_U: begin
                imm_next = {instruction[31:12], 12'b0};
            end
            rv_decoder_pkg::FMT_J: begin
                imm_next = {{(`XLEN-21){sign}}, sign, instruction[19:12],
                            instruction[20], instruction[30:21], 1'b0};
            end
            default: begin    // FMT_NONE
                imm_next     = '0;
                has_imm_next = 1'b0;
            end
        endcase
    end

endmodule

// ==== design/rv_decoder.sv ====
`timescale 1ns/1ns

module rv_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  rv_decoder_pkg::word_t     instruction,
    output rv_decoder_pkg::op_e       op,
    output rv_decoder_pkg::reg_addr_t rs1,
    output rv_decoder_pkg::reg_addr_t rs2,
    output rv_decoder_pkg::reg_addr_t rd,
    output rv_decoder_pkg::word_t     imm,
    output logic                      has_imm
);

    rv_decoder_pkg::op_e       op_next;
    rv_decoder_pkg::imm_fmt_e  fmt;
    rv_decoder_pkg::word_t     imm_next;
    logic                      has_imm_next;
    rv_decoder_pkg::reg_addr_t rs1_next;
    rv_decoder_pkg::reg_addr_t rs2_next;
    rv_decoder_pkg::reg_addr_t rd_next;

    rv_op_decode u_op_decode (
        .instruction (instruction),
        .op_next     (op_next),
        .fmt         (fmt)
    );

    rv_imm_gen u_imm_gen (
        .instruction  (instruction),
        .fmt          (fmt),
        .imm_next     (imm_next),
        .has_imm_next (has_imm_next)
    );

    // Register fields only where the format carries them
    always_comb begin
        rs1_next = '0;
        rs2_next = '0;
        rd_next  = '0;
        case (fmt)
            rv_decoder_pkg::FMT_R: begin
                rs1_next = instruction[19:15];
                rs2_next = instruction[24:20];
                rd_next  = instruction[11:7];
            end
            rv_decoder_pkg::FMT_I, rv_decoder_pkg::FMT_SHAMT: begin
                rs1_next = instruction[19:15];
                rd_next  = instruction[11:7];
            end
            rv_decoder_pkg::FMT_S, rv_decoder_pkg::FMT_B: begin
                rs1_next = instruction[19:15];
                rs2_next = instruction[24:20];
            end
            rv_decoder_pkg::FMT_U, rv_decoder_pkg::FMT_J: rd_next = instruction[11:7];
            default: ;    // Illegal word leaves all fields zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            op      <= rv_decoder_pkg::OP_NONE;
            rs1     <= '0;
            rs2     <= '0;
            rd      <= '0;
            imm     <= '0;
            has_imm <= 1'b0;
        end else begin
            op      <= op_next;
            rs1     <= rs1_next;
            rs2     <= rs2_next;
            rd      <= rd_next;
            imm     <= imm_next;
            has_imm <= has_imm_next;
        end
    end

endmodule

// ==== tests/rv_decoder_chk.sv ====
`timescale 1ns/1ns

module rv_decoder_chk (
    input logic                      clk,
    input logic                      rst,
    input rv_decoder_pkg::op_e       op,
    input rv_decoder_pkg::reg_addr_t rd,
    input rv_decoder_pkg::word_t     imm,
    input logic                      has_imm
);

    int unsigned fail_count = 0;    // Failed assertions so far

    // Reset wins over whatever instruction is present
    assert property (@(posedge clk) !rst |=> op == rv_decoder_pkg::OP_NONE)
        else begin fail_count++; $error("op not cleared one cycle after reset"); end

    assert property (@(posedge clk) disable iff (!rst)
        op == rv_decoder_pkg::OP_NONE |-> !has_imm && imm == '0)
        else begin fail_count++; $error("Illegal slot carries an immediate"); end

    // Stores and branches write no register
    assert property (@(posedge clk) disable iff (!rst)
        op inside {rv_decoder_pkg::OP_SB, rv_decoder_pkg::OP_SH, rv_decoder_pkg::OP_SW,
                   rv_decoder_pkg::OP_BEQ, rv_decoder_pkg::OP_BNE, rv_decoder_pkg::OP_BLT,
                   rv_decoder_pkg::OP_BGE, rv_decoder_pkg::OP_BLTU, rv_decoder_pkg::OP_BGEU}
        |-> rd == '0)
        else begin fail_count++; $error("rd not zero for a store or branch"); end

    assert property (@(posedge clk) disable iff (!rst)
        !has_imm && op != rv_decoder_pkg::OP_NONE |-> imm == '1)
        else begin fail_count++; $error("Register-register op without all-ones immediate"); end

endmodule

bind rv_decoder rv_decoder_chk u_rv_decoder_chk (
    .clk     (clk),
    .rst     (rst),
    .op      (op),
    .rd      (rd),
    .imm     (imm),
    .has_imm (has_imm)
);

// ==== tests/rv_decoder_tb.sv ====
`timescale 1ns/1ns

module rv_decoder_tb;

    typedef struct packed {
        rv_decoder_pkg::word_t     instr;
        rv_decoder_pkg::op_e       op;
        rv_decoder_pkg::reg_addr_t rs1;
        rv_decoder_pkg::reg_addr_t rs2;
        rv_decoder_pkg::reg_addr_t rd;
        rv_decoder_pkg::word_t     imm;
        logic                      has_imm;
    } row_t;

    logic                      clk;
    logic                      rst;
    rv_decoder_pkg::word_t     instruction;
    rv_decoder_pkg::op_e       op;
    rv_decoder_pkg::reg_addr_t rs1;
    rv_decoder_pkg::reg_addr_t rs2;
    rv_decoder_pkg::reg_addr_t rd;
    rv_decoder_pkg::word_t     imm;
    logic                      has_imm;

    row_t rows[$];
    int   errors = 0;
    int   cycles = 0;

    rv_decoder u_rv_decoder (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .has_imm     (has_imm)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset, table and 10 spare cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > rows.size() + 15) begin
            $display("Timeout: run did not finish after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic row_t make_row(input rv_decoder_pkg::word_t instr,
                                      input rv_decoder_pkg::op_e op_exp,
                                      input int rs1_exp, input int rs2_exp, input int rd_exp,
                                      input rv_decoder_pkg::word_t imm_exp,
                                      input logic has_imm_exp);
        row_t r;
        r.instr   = instr;
        r.op      = op_exp;
        r.rs1     = rv_decoder_pkg::reg_addr_t'(rs1_exp);
        r.rs2     = rv_decoder_pkg::reg_addr_t'(rs2_exp);
        r.rd      = rv_decoder_pkg::reg_addr_t'(rd_exp);
        r.imm     = imm_exp;
        r.has_imm = has_imm_exp;
        return r;
    endfunction

    task automatic add_row(input rv_decoder_pkg::word_t instr, input rv_decoder_pkg::op_e op_exp,
                           input int rs1_exp, input int rs2_exp, input int rd_exp,
                           input rv_decoder_pkg::word_t imm_exp, input logic has_imm_exp);
        rows.push_back(make_row(instr, op_exp, rs1_exp, rs2_exp, rd_exp, imm_exp, has_imm_exp));
    endtask

    task automatic check_op(input string name, input rv_decoder_pkg::op_e exp,
                            input rv_decoder_pkg::op_e act);
        if (act !== exp) begin
            $display("MISMATCH %0t ns %s expected %s got %s", $time, name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input rv_decoder_pkg::reg_addr_t exp,
                             input rv_decoder_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("MISMATCH %0t ns %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_imm(input string name, input rv_decoder_pkg::word_t exp,
                             input rv_decoder_pkg::word_t act);
        if (act !== exp) begin
            $display("MISMATCH %0t ns %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %0t ns %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_row(input row_t r);
        check_op("op", r.op, op);
        check_reg("rs1", r.rs1, rs1);
        check_reg("rs2", r.rs2, rs2);
        check_reg("rd", r.rd, rd);
        check_imm("imm", r.imm, imm);
        check_flag("has_imm", r.has_imm, has_imm);
    endtask

    // Words hand-assembled from the base ISA encodings
    task automatic fill_table();
        add_row(32'h1234_50b7, rv_decoder_pkg::OP_LUI, 0, 0, 1, 32'h1234_5000, 1'b1);
        add_row(32'hffff_f117, rv_decoder_pkg::OP_AUIPC, 0, 0, 2, 32'hffff_f000, 1'b1);
        add_row(32'h0030_10ef, rv_decoder_pkg::OP_JAL, 0, 0, 1, 32'h0000_1802, 1'b1);
        add_row(32'hffdf_f2ef, rv_decoder_pkg::OP_JAL, 0, 0, 5, 32'hffff_fffc, 1'b1);
        add_row(32'hff81_00e7, rv_decoder_pkg::OP_JALR, 2, 0, 1, 32'hffff_fff8, 1'b1);
        add_row(32'h0042_0183, rv_decoder_pkg::OP_LB, 4, 0, 3, 32'h0000_0004, 1'b1);
        add_row(32'hffe3_1283, rv_decoder_pkg::OP_LH, 6, 0, 5, 32'hffff_fffe, 1'b1);
        add_row(32'h7ff4_2383, rv_decoder_pkg::OP_LW, 8, 0, 7, 32'h0000_07ff, 1'b1);
        add_row(32'h8005_4483, rv_decoder_pkg::OP_LBU, 10, 0, 9, 32'hffff_f800, 1'b1);
        add_row(32'h0106_5583, rv_decoder_pkg::OP_LHU, 12, 0, 11, 32'h0000_0010, 1'b1);
        add_row(32'h00d7_02a3, rv_decoder_pkg::OP_SB, 14, 13, 0, 32'h0000_0005, 1'b1);
        add_row(32'hfef8_1a23, rv_decoder_pkg::OP_SH, 16, 15, 0, 32'hffff_fff4, 1'b1);
        add_row(32'h0719_2223, rv_decoder_pkg::OP_SW, 18, 17, 0, 32'h0000_0064, 1'b1);
        add_row(32'h0020_8463, rv_decoder_pkg::OP_BEQ, 1, 2, 0, 32'h0000_0008, 1'b1);
        add_row(32'hfe41_98e3, rv_decoder_pkg::OP_BNE, 3, 4, 0, 32'hffff_fff0, 1'b1);
        add_row(32'h0062_c0e3, rv_decoder_pkg::OP_BLT, 5, 6, 0, 32'h0000_0800, 1'b1);
        add_row(32'h8083_d063, rv_decoder_pkg::OP_BGE, 7, 8, 0, 32'hffff_f000, 1'b1);
        add_row(32'h02a4_e063, rv_decoder_pkg::OP_BLTU, 9, 10, 0, 32'h0000_0020, 1'b1);
        add_row(32'hfec5_ffe3, rv_decoder_pkg::OP_BGEU, 11, 12, 0, 32'hffff_fffe, 1'b1);
        add_row(32'hfff1_0093, rv_decoder_pkg::OP_ADD, 2, 0, 1, 32'hffff_ffff, 1'b1);
        add_row(32'h0642_2193, rv_decoder_pkg::OP_SLT, 4, 0, 3, 32'h0000_0064, 1'b1);
        add_row(32'hffb3_3293, rv_decoder_pkg::OP_SLTU, 6, 0, 5, 32'hffff_fffb, 1'b1);
        add_row(32'h01f4_1393, rv_decoder_pkg::OP_SLL, 8, 0, 7, 32'h0000_001f, 1'b1);
        add_row(32'h0075_5493, rv_decoder_pkg::OP_SRL, 10, 0, 9, 32'h0000_0007, 1'b1);
        add_row(32'h4116_5593, rv_decoder_pkg::OP_SRA, 12, 0, 11, 32'h0000_0011, 1'b1);
        add_row(32'h00c5_8533, rv_decoder_pkg::OP_ADD, 11, 12, 10, 32'hffff_ffff, 1'b0);
        add_row(32'h40c5_8533, rv_decoder_pkg::OP_SUB, 11, 12, 10, 32'hffff_ffff, 1'b0);
        add_row(32'h00c5_9533, rv_decoder_pkg::OP_SLL, 11, 12, 10, 32'hffff_ffff, 1'b0);
        add_row(32'h00c5_a533, rv_decoder_pkg::OP_SLT, 11, 12, 10, 32'hffff_ffff, 1'b0);
        add_row(32'h00c5_b533, rv_decoder_pkg::OP_SLTU, 11, 12, 10, 32'hffff_ffff, 1'b0);
        add_row(32'h00c5_c533, rv_decoder_pkg::OP_XOR, 11, 12, 10, 32'hffff_ffff, 1'b0);
        add_row(32'h00c5_d533, rv_decoder_pkg::OP_SRL, 11, 12, 10, 32'hffff_ffff, 1'b0);
        add_row(32'h40c5_d533, rv_decoder_pkg::OP_SRA, 11, 12, 10, 32'hffff_ffff, 1'b0);
        add_row(32'h00c5_e533, rv_decoder_pkg::OP_OR, 11, 12, 10, 32'hffff_ffff, 1'b0);
        add_row(32'h00c5_f533, rv_decoder_pkg::OP_AND, 11, 12, 10, 32'hffff_ffff, 1'b0);
        add_row(32'h0000_0000, rv_decoder_pkg::OP_NONE, 0, 0, 0, 32'h0000_0000, 1'b0);
        add_row(32'h0081_3083, rv_decoder_pkg::OP_NONE, 0, 0, 0, 32'h0000_0000, 1'b0);  // LD
        add_row(32'h0000_4501, rv_decoder_pkg::OP_NONE, 0, 0, 0, 32'h0000_0000, 1'b0);  // c.li
        add_row(32'habcd_efb7, rv_decoder_pkg::OP_LUI, 0, 0, 31, 32'habcd_e000, 1'b1);
        add_row(32'h01df_0fb3, rv_decoder_pkg::OP_ADD, 30, 29, 31, 32'hffff_ffff, 1'b0);
    endtask

    initial begin
        row_t idle;
        fill_table();
        idle = make_row('0, rv_decoder_pkg::OP_NONE, 0, 0, 0, '0, 1'b0);
        rst = 1'b0;
        instruction = '0;
        repeat (4) begin
            @(posedge clk);
            instruction <= 32'h1234_50b7;    // Valid word must not leak through reset
            @(negedge clk);
            check_row(idle);
        end
        @(posedge clk);
        rst <= 1'b1;
        instruction <= rows[0].instr;
        @(negedge clk);
        check_row(idle);    // Last reset edge
        for (int i = 1; i <= rows.size(); i++) begin
            @(posedge clk);
            if (i < rows.size()) begin
                instruction <= rows[i].instr;
            end else begin
                instruction <= '0;
            end
            @(negedge clk);
            check_row(rows[i-1]);
        end
        $display("Checked %0d rows: %0d mismatches, %0d assertion failures",
                 rows.size(), errors, u_rv_decoder.u_rv_decoder_chk.fail_count);
        if (errors == 0 && u_rv_decoder.u_rv_decoder_chk.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_decoder.f ====
+incdir+design
design/rv_decoder_pkg.sv
design/rv_op_decode.sv
design/rv_imm_gen.sv
design/rv_decoder.sv
tests/rv_decoder_chk.sv
tests/rv_decoder_tb.sv

// ==== Makefile ====
# Verilator flow for the RV32I decoder

VERILATOR ?= verilator
TOP       ?= rv_decoder_tb
FILELIST  ?= rv_decoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
